// ==== hdl/qspim_config.svh ====
// ----------------------------------------
// Build time sizes for the quad SPI master
// FIFO depths need not be powers of two
// ----------------------------------------
`ifndef QSPIM_CONFIG_SVH
`define QSPIM_CONFIG_SVH

`define QSPIM_CMD_DEPTH 4  // Queued transactions
`define QSPIM_RES_DEPTH 4  // Unread read words
`define QSPIM_DIV_W     8  // SPI clock divider field
`define QSPIM_REG_AW    3  // Host register address

`endif

// ==== hdl/qspim_cmd_pkg.sv ====
// ----------------------------------------
// Transaction types between pipeline stages
// Address is fixed at 24 bits
// ----------------------------------------
`default_nettype none

package qspim_cmd_pkg;

    typedef logic [31:0] word_t;  // One data word

    // Lane usage after the command byte
    typedef enum logic {
        MODE_SINGLE = 1'b0,
        MODE_QUAD   = 1'b1
    } spi_mode_e;

    // One complete SPI transaction
    typedef struct packed {
        logic        wr;     // Write when set
        spi_mode_e   mode;
        logic [7:0]  cmd;    // Always sent on lane 0
        logic [23:0] addr;
        logic [3:0]  dummy;  // Dummy SPI clocks
        word_t       wdata;  // Unused for reads
    } spi_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/qspim_reg_pkg.sv ====
// ----------------------------------------
// Host register map and status flags
// ----------------------------------------
`default_nettype none
`include "qspim_config.svh"

package qspim_reg_pkg;

    typedef enum logic [`QSPIM_REG_AW-1:0] {
        REG_CFG    = 0,  // Divider in low bits
        REG_CMD    = 1,  // Byte [7:0] quad [8] dummy [15:12] write [16]
        REG_WDATA  = 2,
        REG_ADDR   = 3,  // Write queues a transaction
        REG_RDATA  = 4,  // Read pops a result
        REG_STATUS = 5
    } reg_addr_e;

    // Read back in the low three bits
    typedef struct packed {
        logic cmd_empty;  // Bit 2
        logic res_empty;  // Bit 1
        logic busy;       // Bit 0
    } status_t;

endpackage

`default_nettype wire

// ==== hdl/qspim_fifo_if.sv ====
// ----------------------------------------
// FIFO link with first word fall through
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

interface qspim_fifo_if #(
    parameter type T = logic [31:0]
);
    logic wr;     // Push, only while not full
    T     wdata;
    logic full;
    logic rd;     // Pop, only while not empty
    T     rdata;  // Head of queue
    logic empty;

    modport producer (output wr, output wdata, input full, input empty);
    modport consumer (output rd, input rdata, input empty, input full);
    modport fifo     (input wr, input wdata, input rd,
                      output full, output rdata, output empty);
endinterface

`default_nettype wire

// ==== hdl/qspim_fifo.sv ====
// ----------------------------------------
// Synchronous FIFO, head visible before pop
// Push when full and pop when empty are dropped
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module qspim_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 4
) (
    input wire         mclk,
    input wire         arst_n_i,
    qspim_fifo_if.fifo link
);
    localparam int          AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);
    localparam logic [AW-1:0] LAST   = AW'(DEPTH - 1);

    T              mem [DEPTH];  // Storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;        // Entries held
    logic          push;
    logic          pop;

    assign push        = link.wr && !link.full;
    assign pop         = link.rd && !link.empty;
    assign link.full   = (count == FULL_CNT);
    assign link.empty  = (count == '0);
    assign link.rdata  = mem[rd_ptr];  // Fall through

    always_ff @(posedge mclk) begin
        if (push) begin
            mem[wr_ptr] <= link.wdata;
        end
    end

    always_ff @(posedge mclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/qspim_host_if.sv ====
// ----------------------------------------
// Host register decode, one access at a time
// req_i must be held until ack_o
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps
`include "qspim_config.svh"

module qspim_host_if (
    input  wire                        mclk,
    input  wire                        arst_n_i,
    input  wire                        req_i,
    input  wire                        we_i,
    input  wire qspim_reg_pkg::reg_addr_e addr_i,
    input  wire qspim_cmd_pkg::word_t  wdata_i,
    output logic                       ack_o,
    output qspim_cmd_pkg::word_t       rdata_o,
    output logic [`QSPIM_DIV_W-1:0]    clk_div_o,
    input  wire                        busy_i,
    qspim_fifo_if.producer             cmd_o,
    qspim_fifo_if.consumer             res_i
);
    // Configuration held across transactions
    logic [7:0]                cmd_byte_q;
    qspim_cmd_pkg::spi_mode_e  mode_q;
    logic [3:0]                dummy_q;
    logic                      wr_q;
    qspim_cmd_pkg::word_t      wdata_q;
    logic [23:0]               addr_q;
    logic                      cmd_wr;   // Push pulse
    logic                      res_rd;   // Pop pulse
    logic                      access;   // New access pending
    qspim_reg_pkg::status_t    stat;
    qspim_cmd_pkg::spi_cmd_t   cmd_word;
    qspim_cmd_pkg::word_t      rd_word;

    assign access   = req_i && !ack_o;  // Ack cycle is not a new request
    assign cmd_o.wr = cmd_wr;
    assign res_i.rd = res_rd;

    // Transaction built from the held registers
    always_comb begin
        cmd_word.wr    = wr_q;
        cmd_word.mode  = mode_q;
        cmd_word.cmd   = cmd_byte_q;
        cmd_word.addr  = addr_q;
        cmd_word.dummy = dummy_q;
        cmd_word.wdata = wdata_q;
    end
    assign cmd_o.wdata = cmd_word;

    // ---------------------------------------
    // Read mux
    // ---------------------------------------
    always_comb begin
        stat.cmd_empty = cmd_o.empty;
        stat.res_empty = res_i.empty;
        stat.busy      = busy_i;
        case (addr_i)
            qspim_reg_pkg::REG_CFG:    rd_word = 32'(clk_div_o);
            qspim_reg_pkg::REG_CMD:    rd_word = {15'd0, wr_q, dummy_q, 3'd0, mode_q, cmd_byte_q};
            qspim_reg_pkg::REG_RDATA:  rd_word = res_i.rdata;  // Head of results
            qspim_reg_pkg::REG_STATUS: rd_word = 32'(stat);
            default:                   rd_word = '0;
        endcase
    end

    // Payload capture, refreshed every wait cycle
    always_ff @(posedge mclk) begin
        if (access) begin
            if (we_i && addr_i == qspim_reg_pkg::REG_WDATA) begin
                wdata_q <= wdata_i;
            end
            if (we_i && addr_i == qspim_reg_pkg::REG_ADDR) begin
                addr_q <= wdata_i[23:0];
            end
            if (!we_i) begin
                rdata_o <= rd_word;
            end
        end
    end

    // ---------------------------------------
    // Decode and acknowledge
    // ---------------------------------------
    always_ff @(posedge mclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o      <= 1'b0;
            cmd_wr     <= 1'b0;
            res_rd     <= 1'b0;
            clk_div_o  <= '0;
            cmd_byte_q <= '0;
            mode_q     <= qspim_cmd_pkg::MODE_SINGLE;
            dummy_q    <= '0;
            wr_q       <= 1'b0;
        end else begin
            ack_o  <= 1'b0;  // Single cycle pulse
            cmd_wr <= 1'b0;
            res_rd <= 1'b0;
            if (access && we_i) begin
                case (addr_i)
                    qspim_reg_pkg::REG_CFG: begin
                        clk_div_o <= wdata_i[`QSPIM_DIV_W-1:0];
                        ack_o     <= 1'b1;
                    end
                    qspim_reg_pkg::REG_CMD: begin
                        cmd_byte_q <= wdata_i[7:0];
                        mode_q     <= qspim_cmd_pkg::spi_mode_e'(wdata_i[8]);
                        dummy_q    <= wdata_i[15:12];
                        wr_q       <= wdata_i[16];
                        ack_o      <= 1'b1;
                    end
                    qspim_reg_pkg::REG_ADDR: begin
                        cmd_wr <= !cmd_o.full;  // Back pressure holds ack
                        ack_o  <= !cmd_o.full;
                    end
                    default: ack_o <= 1'b1;  // WDATA and unmapped
                endcase
            end else if (access) begin
                if (addr_i == qspim_reg_pkg::REG_RDATA) begin
                    res_rd <= !res_i.empty;  // Waits for a result
                    ack_o  <= !res_i.empty;
                end else begin
                    ack_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/qspim_ctrl.sv ====
// ----------------------------------------
// SPI mode 0 sequencer, one chip select
// SPI clock half period is clk_div_i+1 mclk
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps
`include "qspim_config.svh"

module qspim_ctrl (
    input  wire                     mclk,
    input  wire                     arst_n_i,
    input  wire [`QSPIM_DIV_W-1:0]  clk_div_i,
    qspim_fifo_if.consumer          cmd_i,
    qspim_fifo_if.producer          res_o,
    output logic                    busy_o,
    output logic                    spi_clk_o,
    output logic                    spi_csn_o,
    output logic [3:0]              spi_sdo_o,
    output logic [3:0]              spi_oen_o,   // Active low
    input  wire  [3:0]              spi_sdi_i
);
    typedef enum logic [2:0] {
        PH_IDLE, PH_CMD, PH_ADDR, PH_DUMMY, PH_DATA, PH_DONE
    } phase_e;

    phase_e                   phase;
    qspim_cmd_pkg::spi_cmd_t  cur;      // Transaction on the pins
    qspim_cmd_pkg::word_t     sh;       // Shift register, MSB first
    logic [`QSPIM_DIV_W-1:0]  div_cnt;
    logic [5:0]               bit_cnt;  // Rising edges in phase
    logic [5:0]               ph_len;
    logic                     is_quad;
    logic                     lane_quad;
    logic                     rd_data;  // Read data phase
    logic                     tick;
    logic                     rise;
    logic                     fall;
    logic                     ph_end;
    logic                     start;

    assign is_quad   = (cur.mode == qspim_cmd_pkg::MODE_QUAD);
    assign lane_quad = is_quad && (phase != PH_CMD);  // Command byte always single
    assign rd_data   = (phase == PH_DATA) && !cur.wr;
    assign tick      = (phase inside {PH_CMD, PH_ADDR, PH_DUMMY, PH_DATA})
                       && (div_cnt == clk_div_i);
    assign rise      = tick && !spi_clk_o;
    assign fall      = tick && spi_clk_o;
    assign ph_end    = fall && (bit_cnt == ph_len);

    // Reads also need room for the result
    assign start     = (phase == PH_IDLE) && !cmd_i.empty
                       && (cmd_i.rdata.wr || !res_o.full);
    assign cmd_i.rd    = start;
    assign res_o.wr    = (phase == PH_DONE) && !cur.wr;
    assign res_o.wdata = sh;
    assign busy_o      = (phase != PH_IDLE);

    always_comb begin
        case (phase)
            PH_CMD:   ph_len = 6'd8;
            PH_ADDR:  ph_len = is_quad ? 6'd6 : 6'd24;
            PH_DUMMY: ph_len = {2'b00, cur.dummy};
            PH_DATA:  ph_len = is_quad ? 6'd8 : 6'd32;
            default:  ph_len = '0;
        endcase
    end

    // ---------------------------------------
    // Pin drive
    // ---------------------------------------
    always_comb begin
        if (spi_csn_o) begin
            spi_sdo_o = 4'hF;
            spi_oen_o = 4'hF;  // Bus released
        end else if (lane_quad) begin
            spi_sdo_o = sh[31:28];
            // Memory owns the lanes from dummy on
            spi_oen_o = (!cur.wr && phase inside {PH_DUMMY, PH_DATA, PH_DONE}) ? 4'hF : 4'h0;
        end else begin
            spi_sdo_o = {2'b11, 1'b0, sh[31]};  // WP and HOLD high
            spi_oen_o = 4'b0010;                // Lane 1 is MISO
        end
    end

    // ---------------------------------------
    // Phase FSM and SPI clock
    // ---------------------------------------
    always_ff @(posedge mclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase     <= PH_IDLE;
            spi_csn_o <= 1'b1;
            spi_clk_o <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
        end else begin
            if (tick) begin
                div_cnt   <= '0;
                spi_clk_o <= !spi_clk_o;
            end else if (busy_o && phase != PH_DONE) begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        phase     <= PH_CMD;
                        spi_csn_o <= 1'b0;
                        div_cnt   <= '0;
                        bit_cnt   <= '0;
                    end
                end
                PH_CMD, PH_ADDR, PH_DUMMY, PH_DATA: begin
                    if (ph_end) begin
                        bit_cnt <= '0;
                        case (phase)
                            PH_CMD:   phase <= PH_ADDR;
                            PH_ADDR:  phase <= (cur.dummy == '0) ? PH_DATA : PH_DUMMY;
                            PH_DUMMY: phase <= PH_DATA;
                            default:  phase <= PH_DONE;  // Clock already low
                        endcase
                    end
                end
                default: begin
                    phase     <= PH_IDLE;
                    spi_csn_o <= 1'b1;
                end
            endcase
        end
    end

    // Shift out on fall, sample on rise
    always_ff @(posedge mclk) begin
        if (start) begin
            cur <= cmd_i.rdata;
            sh  <= {cmd_i.rdata.cmd, 24'h0};
        end else if (ph_end) begin
            if (phase == PH_CMD) begin
                sh <= {cur.addr, 8'h0};
            end else if (phase inside {PH_ADDR, PH_DUMMY}) begin
                sh <= cur.wdata;  // Overwritten by a read
            end
        end else if (fall && !rd_data) begin
            sh <= lane_quad ? {sh[27:0], 4'h0} : {sh[30:0], 1'b0};
        end else if (rise && rd_data) begin
            sh <= lane_quad ? {sh[27:0], spi_sdi_i} : {sh[30:0], spi_sdi_i[1]};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/qspim_top.sv ====
// ----------------------------------------
// Quad SPI master, single host port
// Reset is used without synchronizer
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps
`include "qspim_config.svh"

module qspim_top (
    input  wire                      mclk,
    input  wire                      arst_n_i,
    input  wire                      req_i,
    input  wire                      we_i,
    input  wire [`QSPIM_REG_AW-1:0]  addr_i,
    input  wire [31:0]               wdata_i,
    output logic                     ack_o,
    output logic [31:0]              rdata_o,
    output logic                     spi_clk_o,
    output logic                     spi_csn_o,
    output logic [3:0]               spi_sdo_o,
    output logic [3:0]               spi_oen_o,
    input  wire [3:0]                spi_sdi_i
);
    logic [`QSPIM_DIV_W-1:0] clk_div;  // REG_CFG to sequencer
    logic                    busy;

    qspim_fifo_if #(.T(qspim_cmd_pkg::spi_cmd_t)) cmd_link ();
    qspim_fifo_if #(.T(qspim_cmd_pkg::word_t))    res_link ();

    qspim_host_if u_host_if (
        .mclk      (mclk),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .we_i      (we_i),
        .addr_i    (qspim_reg_pkg::reg_addr_e'(addr_i)),
        .wdata_i   (wdata_i),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .clk_div_o (clk_div),
        .busy_i    (busy),
        .cmd_o     (cmd_link.producer),
        .res_i     (res_link.consumer)
    );

    // Host to sequencer
    qspim_fifo #(.T(qspim_cmd_pkg::spi_cmd_t), .DEPTH(`QSPIM_CMD_DEPTH)) u_cmd_fifo (
        .mclk     (mclk),
        .arst_n_i (arst_n_i),
        .link     (cmd_link.fifo)
    );

    // Read words back to host
    qspim_fifo #(.T(qspim_cmd_pkg::word_t), .DEPTH(`QSPIM_RES_DEPTH)) u_res_fifo (
        .mclk     (mclk),
        .arst_n_i (arst_n_i),
        .link     (res_link.fifo)
    );

    qspim_ctrl u_ctrl (
        .mclk      (mclk),
        .arst_n_i  (arst_n_i),
        .clk_div_i (clk_div),
        .cmd_i     (cmd_link.consumer),
        .res_o     (res_link.producer),
        .busy_o    (busy),
        .spi_clk_o (spi_clk_o),
        .spi_csn_o (spi_csn_o),
        .spi_sdo_o (spi_sdo_o),
        .spi_oen_o (spi_oen_o),
        .spi_sdi_i (spi_sdi_i)
    );

endmodule

`default_nettype wire

// ==== tb/qspim_mem_model.sv ====
// ----------------------------------------
// SPI flash model, mode 0, commands 03h EBh 02h 32h
// EBh has 4 dummy clocks, unwritten words read A5h over address
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module qspim_mem_model (
    input  wire        spi_clk_i,
    input  wire        spi_csn_i,
    input  wire  [3:0] spi_sdo_i,
    output logic [3:0] spi_sdi_o
);
    logic [31:0] mem [logic [23:0]];  // Sparse storage
    logic [7:0]  cmd_q    = 8'h00;
    logic [23:0] addr_q   = '0;
    logic [31:0] data_q   = '0;       // Incoming write word
    logic [31:0] out_q    = '1;       // Outgoing read word
    int          rise_cnt = 0;        // Rising edges since select
    logic        quad;
    logic        is_rd;
    logic        is_wr;
    int          addr_end;
    int          dum_end;
    int          data_end;

    assign quad     = (cmd_q == 8'hEB) || (cmd_q == 8'h32);
    assign is_rd    = (cmd_q == 8'h03) || (cmd_q == 8'hEB);
    assign is_wr    = (cmd_q == 8'h02) || (cmd_q == 8'h32);
    assign addr_end = quad ? 14 : 32;                        // Command plus address
    assign dum_end  = addr_end + ((cmd_q == 8'hEB) ? 4 : 0);
    assign data_end = dum_end + (quad ? 8 : 32);
    assign spi_sdi_o = quad ? out_q[31:28] : {2'b11, out_q[31], 1'b1};  // MISO on lane 1

    // Sample on the rising SPI clock
    always @(posedge spi_clk_i or posedge spi_csn_i) begin
        if (spi_csn_i) begin
            rise_cnt = 0;
        end else begin
            if (rise_cnt < 8) begin
                cmd_q = {cmd_q[6:0], spi_sdo_i[0]};
            end else if (rise_cnt < addr_end) begin
                addr_q = quad ? {addr_q[19:0], spi_sdo_i} : {addr_q[22:0], spi_sdo_i[0]};
            end else if (is_wr && rise_cnt >= dum_end) begin
                data_q = quad ? {data_q[27:0], spi_sdo_i} : {data_q[30:0], spi_sdo_i[0]};
            end
            rise_cnt = rise_cnt + 1;
            if (is_wr && rise_cnt == data_end) begin
                mem[addr_q] = data_q;  // Last data bit in
            end
        end
    end

    // Drive on the falling SPI clock, first bit at end of dummy
    always @(negedge spi_clk_i) begin
        if (!spi_csn_i && is_rd && rise_cnt >= dum_end && rise_cnt < data_end) begin
            if (rise_cnt == dum_end) begin
                out_q <= mem.exists(addr_q) ? mem[addr_q] : {8'hA5, addr_q};
            end else begin
                out_q <= quad ? {out_q[27:0], 4'hF} : {out_q[30:0], 1'b1};
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/qspim_properties.sv ====
// ----------------------------------------
// Pin and host port checks, bound to qspim_top
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module qspim_properties (
    input wire       mclk,
    input wire       arst_n_i,
    input wire       ack_i,
    input wire       spi_clk_i,
    input wire       spi_csn_i,
    input wire [3:0] spi_oen_i
);
    // Bus released while deselected
    a_oen_idle: assert property (@(posedge mclk) disable iff (!arst_n_i)
        spi_csn_i |-> (spi_oen_i == 4'hF))
        else $error("output enables active while chip select is high");

    a_clk_idle: assert property (@(posedge mclk) disable iff (!arst_n_i)
        spi_csn_i |-> !spi_clk_i)  // Mode 0 idle level
        else $error("SPI clock high while chip select is high");

    // Acknowledge is a one cycle pulse
    a_ack_pulse: assert property (@(posedge mclk) disable iff (!arst_n_i)
        ack_i |=> !ack_i)
        else $error("acknowledge high for two cycles");

endmodule

`default_nettype wire

// ==== tb/qspim_tb.sv ====
// ----------------------------------------
// Host level testbench, stops at first mismatch
// Divider starts at 0 after reset
// ----------------------------------------
`default_nettype none
`timescale 1ns/1ps

module qspim_tb;
    localparam int         TIMEOUT       = 20000;  // mclk cycles per wait
    localparam logic [7:0] CMD_RD_SINGLE = 8'h03;
    localparam logic [7:0] CMD_RD_QUAD   = 8'hEB;
    localparam logic [7:0] CMD_WR_SINGLE = 8'h02;
    localparam logic [7:0] CMD_WR_QUAD   = 8'h32;
    localparam logic [3:0] QUAD_DUMMY    = 4'd4;

    typedef enum {OP_CFG, OP_WRITE, OP_READ, OP_ISSUE, OP_POP, OP_STATUS} op_e;

    // One row of the stimulus table
    typedef struct {
        op_e                      op;
        qspim_cmd_pkg::spi_mode_e mode;
        logic [7:0]               cmd;
        logic [3:0]               dummy;
        logic [23:0]              addr;
        qspim_cmd_pkg::word_t     wdata;
        qspim_cmd_pkg::word_t     exp;
        string                    name;
    } entry_t;

    logic                     mclk;
    logic                     arst_n_i;
    logic                     req_i;
    logic                     we_i;
    qspim_reg_pkg::reg_addr_e addr_i;
    qspim_cmd_pkg::word_t     wdata_i;
    logic                     ack_o;
    qspim_cmd_pkg::word_t     rdata_o;
    logic                     spi_clk_o;
    logic                     spi_csn_o;
    logic [3:0]               spi_sdo_o;
    logic [3:0]               spi_oen_o;
    logic [3:0]               spi_sdi_i;
    logic [31:0]              lfsr_state;
    entry_t                   stim_q[$];

    qspim_top DUT (
        .mclk      (mclk),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .spi_clk_o (spi_clk_o),
        .spi_csn_o (spi_csn_o),
        .spi_sdo_o (spi_sdo_o),
        .spi_oen_o (spi_oen_o),
        .spi_sdi_i (spi_sdi_i)
    );

    qspim_mem_model u_mem (
        .spi_clk_i (spi_clk_o),
        .spi_csn_i (spi_csn_o),
        .spi_sdo_i (spi_sdo_o),
        .spi_sdi_o (spi_sdi_i)
    );

    bind qspim_top qspim_properties u_props (
        .mclk      (mclk),
        .arst_n_i  (arst_n_i),
        .ack_i     (ack_o),
        .spi_clk_i (spi_clk_o),
        .spi_csn_i (spi_csn_o),
        .spi_oen_i (spi_oen_o)
    );

    always #20 mclk = ~mclk;  // 40 ns period

    // ----------------------------------------
    // Random source and table building
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic qspim_reg_pkg::status_t idle_status();
        qspim_reg_pkg::status_t s;
        s.cmd_empty = 1'b1;
        s.res_empty = 1'b1;
        s.busy      = 1'b0;
        return s;
    endfunction

    task automatic add_write(input qspim_cmd_pkg::spi_mode_e m, input logic [23:0] a,
                             input qspim_cmd_pkg::word_t d, input string name);
        stim_q.push_back('{OP_WRITE, m,
            (m == qspim_cmd_pkg::MODE_QUAD) ? CMD_WR_QUAD : CMD_WR_SINGLE, 4'd0, a, d, 32'd0, name});
    endtask

    task automatic add_read(input op_e op, input qspim_cmd_pkg::spi_mode_e m,
                            input logic [23:0] a, input qspim_cmd_pkg::word_t exp,
                            input string name);
        stim_q.push_back('{op, m, (m == qspim_cmd_pkg::MODE_QUAD) ? CMD_RD_QUAD : CMD_RD_SINGLE,
            (m == qspim_cmd_pkg::MODE_QUAD) ? QUAD_DUMMY : 4'd0, a, 32'd0, exp, name});
    endtask

    task automatic add_pop(input qspim_cmd_pkg::word_t exp, input string name);
        stim_q.push_back('{OP_POP, qspim_cmd_pkg::MODE_SINGLE, 8'h00, 4'd0, 24'h0, 32'd0, exp, name});
    endtask

    task automatic build_table();
        logic [31:0]          r;
        logic [23:0]          wa [4];
        qspim_cmd_pkg::word_t wd [4];
        add_read(OP_READ, qspim_cmd_pkg::MODE_SINGLE, 24'h012345, {8'hA5, 24'h012345},
                 "unwritten single read");
        // Random addresses keep bit 23 set, fixed ones clear
        for (int k = 0; k < 4; k++) begin
            rand_bits(23, r);
            wa[k] = {1'b1, r[22:0]};
            rand_bits(32, r);
            wd[k] = r;
            if (k % 2 == 0) begin
                add_write(qspim_cmd_pkg::MODE_SINGLE, wa[k], wd[k], "single write");
                add_read(OP_READ, qspim_cmd_pkg::MODE_QUAD, wa[k], wd[k], "quad read back");
            end else begin
                add_write(qspim_cmd_pkg::MODE_QUAD, wa[k], wd[k], "quad write");
                add_read(OP_READ, qspim_cmd_pkg::MODE_SINGLE, wa[k], wd[k], "single read back");
            end
        end
        // Four reads in flight before the first pop
        add_read(OP_ISSUE, qspim_cmd_pkg::MODE_QUAD, wa[0], 32'd0, "issue 0");
        add_read(OP_ISSUE, qspim_cmd_pkg::MODE_SINGLE, 24'h00BEEF, 32'd0, "issue 1");
        add_read(OP_ISSUE, qspim_cmd_pkg::MODE_QUAD, wa[1], 32'd0, "issue 2");
        add_read(OP_ISSUE, qspim_cmd_pkg::MODE_SINGLE, wa[2], 32'd0, "issue 3");
        add_pop(wd[0], "queued read 0");
        add_pop({8'hA5, 24'h00BEEF}, "queued read 1");
        add_pop(wd[1], "queued read 2");
        add_pop(wd[2], "queued read 3");
        // Slower SPI clock
        stim_q.push_back('{OP_CFG, qspim_cmd_pkg::MODE_SINGLE, 8'h00, 4'd0, 24'h0, 32'd5, 32'd0,
                           "divider"});
        add_read(OP_READ, qspim_cmd_pkg::MODE_QUAD, wa[3], wd[3], "slow quad read");
        add_read(OP_READ, qspim_cmd_pkg::MODE_QUAD, 24'h07F00D, {8'hA5, 24'h07F00D},
                 "slow quad read unwritten");
        stim_q.push_back('{OP_STATUS, qspim_cmd_pkg::MODE_SINGLE, 8'h00, 4'd0, 24'h0, 32'd0,
                           32'(idle_status()), "final status"});
    endtask

    // ----------------------------------------
    // Host port and checks
    // ----------------------------------------
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_word(input string name, input qspim_cmd_pkg::word_t exp,
                              input qspim_cmd_pkg::word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_status(input string name, input qspim_reg_pkg::status_t exp,
                                input qspim_reg_pkg::status_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Request held as a level until ack, dropped the cycle after
    task automatic host_access(input logic we, input qspim_reg_pkg::reg_addr_e a,
                               input qspim_cmd_pkg::word_t d, output qspim_cmd_pkg::word_t q);
        int waited;
        waited = 0;
        @(posedge mclk);
        #2;
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = a;
        wdata_i = d;
        do begin
            @(posedge mclk);
            #1;  // Past the edge, outputs settled
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("timeout waiting for host acknowledge");
            end
        end while (!ack_o);
        q = rdata_o;  // Valid with ack
        @(posedge mclk);
        #2;
        req_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        qspim_cmd_pkg::word_t q;
        logic                 wr;
        wr = (e.op == OP_WRITE);
        case (e.op)
            OP_CFG: host_access(1'b1, qspim_reg_pkg::REG_CFG, e.wdata, q);
            OP_POP: begin
                host_access(1'b0, qspim_reg_pkg::REG_RDATA, 32'd0, q);
                check_word(e.name, e.exp, q);
            end
            OP_STATUS: begin
                host_access(1'b0, qspim_reg_pkg::REG_STATUS, 32'd0, q);
                check_status(e.name, qspim_reg_pkg::status_t'(e.exp[2:0]),
                             qspim_reg_pkg::status_t'(q[2:0]));
            end
            default: begin
                // Byte [7:0] quad [8] dummy [15:12] write [16]
                host_access(1'b1, qspim_reg_pkg::REG_CMD,
                            {15'd0, wr, e.dummy, 3'd0, e.mode, e.cmd}, q);
                host_access(1'b1, qspim_reg_pkg::REG_WDATA, e.wdata, q);
                host_access(1'b1, qspim_reg_pkg::REG_ADDR, {8'd0, e.addr}, q);  // Queues it
                if (e.op == OP_READ) begin
                    host_access(1'b0, qspim_reg_pkg::REG_RDATA, 32'd0, q);
                    check_word(e.name, e.exp, q);
                end
            end
        endcase
    endtask

    initial begin
        qspim_cmd_pkg::word_t rd;
        mclk       = 1'b0;
        arst_n_i   = 1'b0;
        req_i      = 1'b0;
        we_i       = 1'b0;
        addr_i     = qspim_reg_pkg::REG_CFG;
        wdata_i    = '0;
        lfsr_state = 32'hc24;
        build_table();
        repeat (3) @(posedge mclk);
        #2;
        arst_n_i = 1'b1;
        // csn, clk, oen packed low bits
        check_word("idle pins", 32'h0000_002F, 32'({spi_csn_o, spi_clk_o, spi_oen_o}));
        host_access(1'b0, qspim_reg_pkg::REG_STATUS, 32'd0, rd);
        check_status("reset status", idle_status(), qspim_reg_pkg::status_t'(rd[2:0]));
        foreach (stim_q[i]) begin
            run_entry(stim_q[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/qspim_cmd_pkg.sv
hdl/qspim_reg_pkg.sv
hdl/qspim_fifo_if.sv
hdl/qspim_fifo.sv
hdl/qspim_host_if.sv
hdl/qspim_ctrl.sv
hdl/qspim_top.sv
tb/qspim_mem_model.sv
tb/qspim_properties.sv
tb/qspim_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --Wno-fatal -f build.f --top-module qspim_tb -o qspim_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/qspim_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
